/* include/cache_defines.svh */
// cache geometry macros, included by every source that sizes tags, sets or lines
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address split: tag | index | offset
`define S_OFFSET 5
`define S_INDEX  3
`define S_TAG    (32 - `S_OFFSET - `S_INDEX)

`define S_MASK   (1 << `S_OFFSET)    // bytes per line
`define S_LINE   (8 * `S_MASK)       // bits per line
`define NUM_SETS (1 << `S_INDEX)
`define NUM_WAYS 2                   // one lru bit per set

`endif

/* hdl/rv32i_types.sv */
// processor word types for the core-facing address and data ports
package rv32i_types;

    // byte address or data word of the core
    typedef logic [31:0] rv32i_word;

endpackage : rv32i_types

/* hdl/cache_types.sv */
// cache-internal types, shared by the control FSM, the datapath and the ways
package cache_types;

    // control FSM states
    typedef enum logic [1:0] {
        CHECK,      // tag lookup, respond on hit
        WRITEBACK,  // dirty victim out to memory
        ALLOCATE    // line fill from memory
    } cache_state_e;

    // what a way writes this cycle
    typedef enum logic [1:0] {
        WAY_IDLE,
        WAY_FILL,   // whole line, valid and tag set, dirty cleared
        WAY_STORE   // enabled bytes only, dirty set
    } way_op_e;

endpackage : cache_types

/* hdl/cache_ctrl_if.sv */
// control strobes and lookup status passed between the cache FSM and its datapath
`include "cache_defines.svh"

interface cache_ctrl_if import cache_types::*; ();

    way_op_e way_op;        // write request for the selected way
    logic set_lru;          // touch the lru bit of the current set
    logic pmem_addr_sel;    // victim tag on pmem_address
    logic hit;
    logic victim_dirty;
    logic [$clog2(`NUM_WAYS)-1:0] hit_way;

    modport ctrl (
        output way_op, set_lru, pmem_addr_sel,
        input  hit, victim_dirty, hit_way
    );

    modport dp (
        input  way_op, set_lru, pmem_addr_sel,
        output hit, victim_dirty, hit_way
    );

endinterface : cache_ctrl_if

/* hdl/cache_way.sv */
// one cache way: per-set tag, valid, dirty and line storage with its own tag compare
`include "cache_defines.svh"

module cache_way import cache_types::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`S_INDEX-1:0]  set_idx,
    input  logic [`S_TAG-1:0]    req_tag,
    input  way_op_e              op,
    input  logic [`S_MASK-1:0]   byte_en,
    input  logic [`S_LINE-1:0]   wdata,
    input  logic [`S_LINE-1:0]   fill_data,
    output logic [`S_LINE-1:0]   line,
    output logic [`S_TAG-1:0]    tag,
    output logic                 hit,
    output logic                 dirty
);

    logic [`S_TAG-1:0]  tag_arr  [`NUM_SETS];
    logic [`S_LINE-1:0] data_arr [`NUM_SETS];
    logic [`NUM_SETS-1:0] valid_arr;
    logic [`NUM_SETS-1:0] dirty_arr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_arr <= '0;
        end
        else if (op == WAY_FILL)
        begin
            valid_arr[set_idx] <= 1'b1;
        end
    end

    // dirty is only looked at together with valid
    always_ff @(posedge clk)
    begin
        unique case (op)
            WAY_FILL:
            begin
                data_arr[set_idx]  <= fill_data;
                tag_arr[set_idx]   <= req_tag;
                dirty_arr[set_idx] <= 1'b0;
            end
            WAY_STORE:
            begin
                for (int b = 0; b < `S_MASK; b++)
                begin
                    if (byte_en[b])
                        data_arr[set_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
                dirty_arr[set_idx] <= 1'b1;
            end
            default: ;  // WAY_IDLE
        endcase
    end

    // combinational read, same-cycle hit
    assign line  = data_arr[set_idx];
    assign tag   = tag_arr[set_idx];
    assign hit   = valid_arr[set_idx] && (tag_arr[set_idx] == req_tag);
    assign dirty = valid_arr[set_idx] && dirty_arr[set_idx];

endmodule : cache_way

/* hdl/cache_datapath.sv */
// cache datapath: address split, lru bits, the ways, victim and hit-data select
`include "cache_defines.svh"

module cache_datapath import rv32i_types::*, cache_types::*; (
    input  logic                clk,
    input  logic                rst,
    input  rv32i_word           mem_address,
    input  logic [`S_MASK-1:0]  mem_byte_enable256,
    input  logic [`S_LINE-1:0]  mem_wdata256,
    input  logic [`S_LINE-1:0]  pmem_rdata,
    output logic [`S_LINE-1:0]  mem_rdata256,
    output logic [`S_LINE-1:0]  pmem_wdata,
    output rv32i_word           pmem_address,
    cache_ctrl_if.dp            dp
);

    localparam int way_w = $clog2(`NUM_WAYS);

    logic [`S_TAG-1:0]    req_tag;
    logic [`S_INDEX-1:0]  set_idx;
    logic [`NUM_SETS-1:0] lru;          // per set, points at the way to replace
    logic [way_w-1:0]     victim_way;
    logic [`NUM_WAYS-1:0] way_hit;
    logic [`NUM_WAYS-1:0] way_dirty;
    logic [`S_LINE-1:0]   way_line [`NUM_WAYS];
    logic [`S_TAG-1:0]    way_tag  [`NUM_WAYS];
    way_op_e              way_ops  [`NUM_WAYS];

    assign req_tag    = mem_address[31 -: `S_TAG];
    assign set_idx    = mem_address[`S_OFFSET +: `S_INDEX];
    assign victim_way = lru[set_idx];

    always_ff @(posedge clk)
    begin
        if (rst)
            lru <= '0;
        else if (dp.set_lru)
            lru[set_idx] <= ~dp.hit_way;    // away from the way just used
    end

    for (genvar w = 0; w < `NUM_WAYS; w++)
    begin : g_way
        // store goes to the hit way, fill to the lru way
        always_comb
        begin
            if (dp.way_op == WAY_STORE && dp.hit && dp.hit_way == way_w'(w))
                way_ops[w] = WAY_STORE;
            else if (dp.way_op == WAY_FILL && victim_way == way_w'(w))
                way_ops[w] = WAY_FILL;
            else
                way_ops[w] = WAY_IDLE;
        end

        cache_way u_way (
            .clk       (clk),
            .rst       (rst),
            .set_idx   (set_idx),
            .req_tag   (req_tag),
            .op        (way_ops[w]),
            .byte_en   (mem_byte_enable256),
            .wdata     (mem_wdata256),
            .fill_data (pmem_rdata),
            .line      (way_line[w]),
            .tag       (way_tag[w]),
            .hit       (way_hit[w]),
            .dirty     (way_dirty[w])
        );
    end

    always_comb
    begin
        dp.hit_way = '0;
        for (int w = 0; w < `NUM_WAYS; w++)
        begin
            if (way_hit[w])
                dp.hit_way = way_w'(w);
        end
    end

    assign dp.hit          = |way_hit;
    assign dp.victim_dirty = way_dirty[victim_way];
    assign mem_rdata256    = way_line[dp.hit_way];
    assign pmem_wdata      = way_line[victim_way];

    // line aligned, victim tag during write-back
    assign pmem_address = dp.pmem_addr_sel
                        ? {way_tag[victim_way], set_idx, {`S_OFFSET{1'b0}}}
                        : {req_tag, set_idx, {`S_OFFSET{1'b0}}};

endmodule : cache_datapath

/* hdl/cache_control.sv */
// cache control FSM: hit response, dirty write-back and line allocate sequencing
module cache_control import cache_types::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic        pmem_resp,
    output logic        mem_resp,
    output logic        pmem_read,
    output logic        pmem_write,
    cache_ctrl_if.ctrl  ctrl
);

    cache_state_e state, state_next;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= CHECK;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next         = state;
        mem_resp           = 1'b0;
        pmem_read          = 1'b0;
        pmem_write         = 1'b0;
        ctrl.way_op        = WAY_IDLE;
        ctrl.set_lru       = 1'b0;
        ctrl.pmem_addr_sel = 1'b0;

        unique case (state)
            CHECK:
            begin
                if (mem_read || mem_write)
                begin
                    if (ctrl.hit)
                    begin
                        mem_resp     = 1'b1;
                        ctrl.set_lru = 1'b1;
                        if (mem_write)
                            ctrl.way_op = WAY_STORE;
                    end
                    else if (ctrl.victim_dirty)
                    begin
                        state_next = WRITEBACK;
                    end
                    else
                    begin
                        state_next = ALLOCATE;
                    end
                end
            end

            WRITEBACK:
            begin
                pmem_write         = 1'b1;
                ctrl.pmem_addr_sel = 1'b1;  // victim line address
                if (pmem_resp)
                    state_next = ALLOCATE;
            end

            ALLOCATE:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.way_op = WAY_FILL;  // rdata valid this cycle only
                    state_next  = CHECK;     // hits on the next lookup
                end
            end

            default:
            begin
                state_next = CHECK;
            end
        endcase
    end

endmodule : cache_control

/* hdl/cache.sv */
// two-way write-back cache top, between the CPU line port and physical memory
`include "cache_defines.svh"

module cache import rv32i_types::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_read,
    input  logic                mem_write,
    input  rv32i_word           mem_address,
    input  logic [`S_MASK-1:0]  mem_byte_enable256,
    input  logic [`S_LINE-1:0]  mem_wdata256,
    output logic [`S_LINE-1:0]  mem_rdata256,
    output logic                mem_resp,
    output logic                pmem_read,
    output logic                pmem_write,
    output rv32i_word           pmem_address,
    output logic [`S_LINE-1:0]  pmem_wdata,
    input  logic [`S_LINE-1:0]  pmem_rdata,
    input  logic                pmem_resp
);

    cache_ctrl_if ctrl_bus ();

    cache_control u_control (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ctrl       (ctrl_bus.ctrl)
    );

    cache_datapath u_datapath (
        .clk                (clk),
        .rst                (rst),
        .mem_address        (mem_address),
        .mem_byte_enable256 (mem_byte_enable256),
        .mem_wdata256       (mem_wdata256),
        .pmem_rdata         (pmem_rdata),
        .mem_rdata256       (mem_rdata256),
        .pmem_wdata         (pmem_wdata),
        .pmem_address       (pmem_address),
        .dp                 (ctrl_bus.dp)
    );

endmodule : cache

/* tb/cache_asserts.sv */
// protocol checks on the cache ports, bound into the cache top by the testbench
module cache_asserts import rv32i_types::*; (
    input logic      clk,
    input logic      rst,
    input logic      mem_read,
    input logic      mem_write,
    input logic      mem_resp,
    input logic      pmem_read,
    input logic      pmem_write,
    input rv32i_word pmem_address,
    input logic      pmem_resp
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    a_pmem_excl: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else
        begin
            $error("pmem_read and pmem_write high together");
            fail_count++;
        end

    // request held with a stable address until the memory answers
    a_read_held: assert property (@(posedge clk) disable iff (rst)
        pmem_read && !pmem_resp |=> pmem_read && $stable(pmem_address))
        else
        begin
            $error("pmem_read dropped or address changed before pmem_resp");
            fail_count++;
        end

    a_write_held: assert property (@(posedge clk) disable iff (rst)
        pmem_write && !pmem_resp |=> pmem_write && $stable(pmem_address))
        else
        begin
            $error("pmem_write dropped or address changed before pmem_resp");
            fail_count++;
        end

    a_resp_req: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> mem_read || mem_write)
        else
        begin
            $error("mem_resp without a CPU request");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !mem_resp && !pmem_read && !pmem_write)
        else
        begin
            $error("cache outputs active in the cycle after reset");
            fail_count++;
        end

endmodule : cache_asserts

/* tb/cache_tb.sv */
// cache testbench: CPU requests from the stimulus file against a line memory model
`include "cache_defines.svh"

module cache_tb import rv32i_types::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_wait = 200;  // cycles per handshake

    logic clk, rst;
    logic mem_read, mem_write, mem_resp;
    rv32i_word mem_address;
    logic [`S_MASK-1:0] mem_byte_enable256;
    logic [`S_LINE-1:0] mem_wdata256, mem_rdata256;
    logic pmem_read, pmem_write, pmem_resp;
    rv32i_word pmem_address;
    logic [`S_LINE-1:0] pmem_wdata, pmem_rdata;

    logic [`S_LINE-1:0] mem_lines [rv32i_word];    // lines written back so far
    logic [31:0] lfsr_state = 32'h4e1a5dce;
    int fill_count, wb_count;
    int value_errors, timeout_errors, other_errors, protocol_errors;

    cache u_dut (.*);

    bind cache cache_asserts u_asserts (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    // unwritten lines hold their own address in every word
    function automatic logic [`S_LINE-1:0] line_at(input rv32i_word addr);
        if (mem_lines.exists(addr))
            return mem_lines[addr];
        return {(`S_LINE / 32){addr}};
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // answers each held request after 1 to 4 cycles
    initial
    begin : mem_model
        int delay;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever
        begin
            @(posedge clk);
            #2;
            pmem_resp = 1'b0;
            if (!rst && (pmem_read || pmem_write))
            begin
                delay = 1 + draw_bits(2);
                repeat (delay)
                begin
                    @(posedge clk);
                    #2;
                end
                assert (pmem_address[`S_OFFSET-1:0] == '0)
                else
                begin
                    $display("ERR %0t: unaligned pmem_address %h", $time, pmem_address);
                    value_errors++;
                end
                if (pmem_write)
                begin
                    mem_lines[pmem_address] = pmem_wdata;
                    wb_count++;
                end
                else
                begin
                    pmem_rdata = line_at(pmem_address);
                    fill_count++;
                end
                pmem_resp = 1'b1;
            end
        end
    end

    task automatic run_request(input logic is_write, input rv32i_word addr,
                               input logic [31:0] be, input logic [31:0] pattern,
                               input logic [31:0] exp_word, input int exp_fills,
                               input int exp_wbs);
        int fills0;
        int wbs0;
        int cycles;
        logic seen;
        logic [`S_LINE-1:0] rdata;
        fills0 = fill_count;
        wbs0   = wb_count;
        cycles = 0;
        seen   = 1'b0;
        mem_address        = addr;
        mem_byte_enable256 = be;
        mem_wdata256       = {(`S_LINE / 32){pattern}};
        mem_read           = !is_write;
        mem_write          = is_write;
        while (!seen && cycles < max_wait)
        begin
            @(negedge clk);     // outputs settled mid-cycle
            if (mem_resp)
            begin
                seen  = 1'b1;
                rdata = mem_rdata256;
            end
            else
                cycles++;
        end
        @(posedge clk);
        #2;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        if (!seen)
        begin
            $display("timeout: no mem_resp within %0d cycles for address %h", max_wait, addr);
            timeout_errors++;
            return;
        end
        assert (fill_count - fills0 == exp_fills)
        else
        begin
            $display("ERR %0t: %h expected %0d line fills, saw %0d",
                     $time, addr, exp_fills, fill_count - fills0);
            value_errors++;
        end
        assert (wb_count - wbs0 == exp_wbs)
        else
        begin
            $display("ERR %0t: %h expected %0d write-backs, saw %0d",
                     $time, addr, exp_wbs, wb_count - wbs0);
            value_errors++;
        end
        // no memory traffic means a hit, answered in the first cycle
        if (exp_fills == 0 && exp_wbs == 0)
            assert (cycles == 0)
            else
            begin
                $display("ERR %0t: hit on %h answered after %0d cycles", $time, addr, cycles);
                value_errors++;
            end
        if (!is_write)
            assert (rdata[31:0] == exp_word)
            else
            begin
                $display("ERR %0t: %h word 0 is %h, expected %h",
                         $time, addr, rdata[31:0], exp_word);
                value_errors++;
            end
        @(posedge clk);
        #2;
    endtask

    initial
    begin : stimulus
        int fd;
        int n;
        string text;
        logic [7:0] op;
        rv32i_word addr;
        logic [31:0] be, pattern, exp_word;
        int exp_fills, exp_wbs;
        rst                = 1'b1;
        mem_read           = 1'b0;
        mem_write          = 1'b0;
        mem_address        = '0;
        mem_byte_enable256 = '0;
        mem_wdata256       = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        fd = $fopen("tb/cache_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file tb/cache_stimulus.txt");
            other_errors++;
        end
        else
        begin
            while ($fgets(text, fd) != 0)
            begin
                if (text.len() < 2 || text[0] == "#")
                    continue;
                n = $sscanf(text, "%c %h %h %h %h %d %d",
                            op, addr, be, pattern, exp_word, exp_fills, exp_wbs);
                if (n != 7)
                begin
                    $display("malformed stimulus line: %s", text);
                    other_errors++;
                end
                else
                    run_request(op == "W", addr, be, pattern, exp_word, exp_fills, exp_wbs);
            end
            $fclose(fd);
        end
        protocol_errors = u_dut.u_asserts.fail_count;
        $display("errors: %0d value, %0d timeout, %0d protocol, %0d other",
                 value_errors, timeout_errors, protocol_errors, other_errors);
        if (value_errors + timeout_errors + protocol_errors + other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule : cache_tb

/* flist.f */
+incdir+include
hdl/rv32i_types.sv
hdl/cache_types.sv
hdl/cache_ctrl_if.sv
hdl/cache_way.sv
hdl/cache_datapath.sv
hdl/cache_control.sv
hdl/cache.sv
tb/cache_asserts.sv
tb/cache_tb.sv

/* Bender.yml */
package:
  name: rv32i_cache

export_include_dirs:
  - include

sources:
  - hdl/rv32i_types.sv
  - hdl/cache_types.sv
  - hdl/cache_ctrl_if.sv
  - hdl/cache_way.sv
  - hdl/cache_datapath.sv
  - hdl/cache_control.sv
  - hdl/cache.sv
  - target: test
    files:
      - tb/cache_asserts.sv
      - tb/cache_tb.sv

/* tb/cache_stimulus.txt */
# op addr byte_en wpattern exp_word0 fills writebacks (hex, except the two counts)
# exp_word0 is checked on reads only, a write response shows the line before the store
R 00001024 00000000 00000000 00001020 1 0
R 00001020 00000000 00000000 00001020 0 0
W 00001020 00000005 aabbccdd 00000000 0 0
R 00001020 00000000 00000000 00bb10dd 0 0
R 00002020 00000000 00000000 00002020 1 0
R 00003020 00000000 00000000 00003020 1 1
R 00001020 00000000 00000000 00bb10dd 1 0
R 00005040 00000000 00000000 00005040 1 0
R 00006040 00000000 00000000 00006040 1 0
R 00005040 00000000 00000000 00005040 0 0
R 00007040 00000000 00000000 00007040 1 0
R 00005040 00000000 00000000 00005040 0 0
R 00007040 00000000 00000000 00007040 0 0
R 00006040 00000000 00000000 00006040 1 0
W 00007044 ffffffff 12345678 00000000 0 0
R 00008040 00000000 00000000 00008040 1 0
R 00009040 00000000 00000000 00009040 1 1
R 00007040 00000000 00000000 12345678 1 0
R 00010000 00000000 00000000 00010000 1 0
